/* hw/textvga_settings.svh */
`ifndef TEXTVGA_SETTINGS_SVH
`define TEXTVGA_SETTINGS_SVH

// Visible area and horizontal raster
`define RES_H 78
`define H_FRONT 4
`define H_SYNC 8
`define H_TOTAL 100

// Vertical raster, counted in lines
`define RES_V 40
`define V_FRONT 2
`define V_SYNC 2
`define V_TOTAL 48

// Glyph size, cell adds one spacing column and one spacing row
`define FONT_W 5
`define FONT_H 7
`define CELL_W (`FONT_W + 1)
`define CELL_H (`FONT_H + 1)

`define GRID_COLS 13
`define GRID_ROWS 5
`define CELL_COUNT (`GRID_COLS * `GRID_ROWS)

`define COLOR_TEXT 3'b111
`define COLOR_BG 3'b001
`define COLOR_SEL_TEXT 3'b010 // Selected row palette
`define COLOR_SEL_BG 3'b110

`endif

/* hw/textvga_pkg.sv */
`default_nettype none

`include "textvga_settings.svh"

package textvga_pkg;

	// Raster counters
	typedef logic [6:0] hpos_t;
	typedef logic [5:0] vpos_t;

	// Cell grid position
	typedef logic [3:0] col_t;
	typedef logic [2:0] row_t;

	// Pixel position inside a cell
	typedef logic [2:0] fontcol_t;
	typedef logic [2:0] fontline_t;

	typedef logic [6:0] char_code_t;
	typedef logic [6:0] cell_idx_t; // row * GRID_COLS + col
	typedef logic [9:0] rom_addr_t; // {fontline, char code}

	// MSB is the leftmost pixel
	typedef logic [`FONT_W-1:0] glyph_row_t;

	typedef logic [2:0] rgb_t;

endpackage

`default_nettype wire

/* hw/cell_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Raster position as produced by the counters
interface cell_if;
	import textvga_pkg::*;

	logic active;
	logic hsync;
	logic vsync;
	col_t col;
	row_t row;
	fontcol_t fontcol;
	fontline_t fontline;

	modport source (output active, hsync, vsync, col, row, fontcol, fontline);
	modport sink (input active, hsync, vsync, col, row, fontcol, fontline);
endinterface

// Position delayed to the cycle where font ROM data is valid
interface glyph_if;
	import textvga_pkg::*;

	logic active;
	logic hsync;
	logic vsync;
	logic selected;
	fontcol_t fontcol;
	fontline_t fontline;

	modport source (output active, hsync, vsync, selected, fontcol, fontline);
	modport sink (input active, hsync, vsync, selected, fontcol, fontline);
endinterface

`default_nettype wire

/* hw/raster_timing.sv */
`timescale 1ns/100ps
`default_nettype none

`include "textvga_settings.svh"

module raster_timing (
	input wire logic clk,
	input wire logic rst_n,
	cell_if.source cells
);
	import textvga_pkg::*;

	localparam hpos_t H_LAST = hpos_t'(`H_TOTAL - 1);
	localparam vpos_t V_LAST = vpos_t'(`V_TOTAL - 1);
	localparam hpos_t H_VIS = hpos_t'(`RES_H);
	localparam vpos_t V_VIS = vpos_t'(`RES_V);
	localparam hpos_t HS_START = hpos_t'(`RES_H + `H_FRONT);
	localparam hpos_t HS_END = hpos_t'(`RES_H + `H_FRONT + `H_SYNC);
	localparam vpos_t VS_START = vpos_t'(`RES_V + `V_FRONT);
	localparam vpos_t VS_END = vpos_t'(`RES_V + `V_FRONT + `V_SYNC);
	localparam fontcol_t FC_LAST = fontcol_t'(`CELL_W - 1);
	localparam fontline_t FL_LAST = fontline_t'(`CELL_H - 1);

	hpos_t hpos;
	vpos_t vpos;
	col_t col;
	fontcol_t fontcol;
	row_t row;
	fontline_t fontline;
	logic line_end;
	logic frame_end;

	assign line_end = (hpos == H_LAST);
	assign frame_end = line_end && (vpos == V_LAST);

	// Horizontal counters, cell counters hold once past the visible area
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hpos <= '0;
			col <= '0;
			fontcol <= '0;
		end else if (line_end) begin
			hpos <= '0;
			col <= '0;
			fontcol <= '0;
		end else begin
			hpos <= hpos + 1'b1;
			if (hpos < H_VIS) begin
				if (fontcol == FC_LAST) begin
					fontcol <= '0;
					col <= col + 1'b1; // Next cell
				end else begin
					fontcol <= fontcol + 1'b1;
				end
			end
		end
	end

	// Vertical counters step once per line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vpos <= '0;
			row <= '0;
			fontline <= '0;
		end else if (frame_end) begin
			vpos <= '0;
			row <= '0;
			fontline <= '0;
		end else if (line_end) begin
			vpos <= vpos + 1'b1;
			if (vpos < V_VIS) begin
				if (fontline == FL_LAST) begin
					fontline <= '0;
					row <= row + 1'b1;
				end else begin
					fontline <= fontline + 1'b1;
				end
			end
		end
	end

	assign cells.active = (hpos < H_VIS) && (vpos < V_VIS);
	assign cells.hsync = (hpos >= HS_START) && (hpos < HS_END); // Active high
	assign cells.vsync = (vpos >= VS_START) && (vpos < VS_END);
	assign cells.col = col;
	assign cells.row = row;
	assign cells.fontcol = fontcol;
	assign cells.fontline = fontline;

endmodule

`default_nettype wire

/* hw/text_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "textvga_settings.svh"

module text_buffer (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic wr_req,
	input wire textvga_pkg::cell_idx_t wr_idx,
	input wire textvga_pkg::char_code_t wr_char,
	input wire textvga_pkg::cell_idx_t rd_idx,
	output logic wr_ack,
	output textvga_pkg::char_code_t rd_char
);
	import textvga_pkg::*;

	typedef enum logic {
		WR_IDLE,
		WR_ACKED
	} wr_state_t;

	localparam cell_idx_t LAST_IDX = cell_idx_t'(`CELL_COUNT - 1);

	char_code_t mem [`CELL_COUNT];
	wr_state_t state;
	logic store;

	// Store on the request edge, out of range index is dropped
	assign store = (state == WR_IDLE) && wr_req && (wr_idx <= LAST_IDX);

	// Four-phase write side
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= WR_IDLE;
		end else begin
			case (state)
				WR_IDLE: begin
					if (wr_req) begin
						state <= WR_ACKED;
					end
				end
				WR_ACKED: begin
					if (!wr_req) begin
						state <= WR_IDLE; // Host released the request
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	assign wr_ack = (state == WR_ACKED);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CELL_COUNT; i++) begin
				mem[i] <= '0; // Blank screen
			end
		end else if (store) begin
			mem[wr_idx] <= wr_char;
		end
	end

	// Blanking area indexes past the grid, read back as blank
	always_ff @(posedge clk) begin
		rd_char <= (rd_idx <= LAST_IDX) ? mem[rd_idx] : '0;
	end

endmodule

`default_nettype wire

/* hw/glyph_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "textvga_settings.svh"

module glyph_fetch (
	input wire logic clk,
	input wire logic rst_n,
	input wire textvga_pkg::row_t sel_row,
	input wire textvga_pkg::char_code_t rd_char,
	cell_if.sink cells,
	output textvga_pkg::cell_idx_t rd_idx,
	output textvga_pkg::rom_addr_t rom_addr,
	glyph_if.source glyph
);
	import textvga_pkg::*;

	localparam fontline_t GLYPH_LAST = fontline_t'(`FONT_H - 1);
	localparam fontline_t SPACE_LINE = fontline_t'(`FONT_H);

	// Stage 0 is buffer read, 1 is ROM address, 2 is ROM data
	logic [2:0] active_d;
	logic [2:0] hsync_d;
	logic [2:0] vsync_d;
	logic [2:0] sel_d;
	fontcol_t fontcol_d [3];
	fontline_t fontline_d [3];
	fontline_t addr_line;

	assign rd_idx = cell_idx_t'(cells.row) * cell_idx_t'(`GRID_COLS)
		+ cell_idx_t'(cells.col);

	// Spacing row is masked later, any glyph line will do
	assign addr_line = (fontline_d[0] == SPACE_LINE) ? GLYPH_LAST : fontline_d[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_d <= '0;
			hsync_d <= '0;
			vsync_d <= '0;
		end else begin
			active_d <= {active_d[1:0], cells.active};
			hsync_d <= {hsync_d[1:0], cells.hsync};
			vsync_d <= {vsync_d[1:0], cells.vsync};
		end
	end

	always_ff @(posedge clk) begin
		sel_d <= {sel_d[1:0], (cells.row == sel_row)};
		fontcol_d[0] <= cells.fontcol;
		fontcol_d[1] <= fontcol_d[0];
		fontcol_d[2] <= fontcol_d[1];
		fontline_d[0] <= cells.fontline;
		fontline_d[1] <= fontline_d[0];
		fontline_d[2] <= fontline_d[1];
		rom_addr <= {addr_line, rd_char}; // rd_char valid this cycle
	end

	assign glyph.active = active_d[2];
	assign glyph.hsync = hsync_d[2];
	assign glyph.vsync = vsync_d[2];
	assign glyph.selected = sel_d[2];
	assign glyph.fontcol = fontcol_d[2];
	assign glyph.fontline = fontline_d[2];

endmodule

`default_nettype wire

/* hw/pixel_shade.sv */
`timescale 1ns/100ps
`default_nettype none

`include "textvga_settings.svh"

module pixel_shade (
	input wire logic clk,
	input wire logic rst_n,
	input wire textvga_pkg::glyph_row_t rom_q,
	glyph_if.sink glyph,
	output textvga_pkg::rgb_t rgb,
	output logic hsync,
	output logic vsync,
	output logic de
);
	import textvga_pkg::*;

	localparam fontcol_t SPACE_COL = fontcol_t'(`FONT_W);
	localparam fontline_t SPACE_LINE = fontline_t'(`FONT_H);

	glyph_row_t shifted;
	logic spacing;
	logic fg;
	rgb_t color;

	// Bring the current pixel to the MSB
	assign shifted = rom_q << glyph.fontcol;
	assign spacing = (glyph.fontcol == SPACE_COL) || (glyph.fontline == SPACE_LINE);
	assign fg = !spacing && shifted[`FONT_W-1];

	always_comb begin
		if (glyph.selected) begin
			color = fg ? `COLOR_SEL_TEXT : `COLOR_SEL_BG;
		end else begin
			color = fg ? `COLOR_TEXT : `COLOR_BG;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rgb <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			de <= 1'b0;
		end else begin
			rgb <= glyph.active ? color : '0; // Black in blanking
			hsync <= glyph.hsync;
			vsync <= glyph.vsync;
			de <= glyph.active;
		end
	end

endmodule

`default_nettype wire

/* hw/textvga_top.sv */
`timescale 1ns/100ps
`default_nettype none

module textvga_top (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic wr_req,
	input wire textvga_pkg::cell_idx_t wr_idx,
	input wire textvga_pkg::char_code_t wr_char,
	input wire textvga_pkg::row_t sel_row,
	input wire textvga_pkg::glyph_row_t rom_q,
	output wire logic wr_ack,
	output wire textvga_pkg::rom_addr_t rom_addr,
	output wire textvga_pkg::rgb_t rgb,
	output wire logic hsync,
	output wire logic vsync,
	output wire logic de
);
	import textvga_pkg::*;

	cell_idx_t rd_idx;
	char_code_t rd_char;

	cell_if cells ();
	glyph_if glyph ();

	raster_timing raster_timing_inst (
		.clk (clk),
		.rst_n (rst_n),
		.cells (cells.source)
	);

	text_buffer text_buffer_inst (
		.clk (clk),
		.rst_n (rst_n),
		.wr_req (wr_req),
		.wr_idx (wr_idx),
		.wr_char (wr_char),
		.rd_idx (rd_idx),
		.wr_ack (wr_ack),
		.rd_char (rd_char)
	);

	// Font ROM sits outside, one cycle read latency
	glyph_fetch glyph_fetch_inst (
		.clk (clk),
		.rst_n (rst_n),
		.sel_row (sel_row),
		.rd_char (rd_char),
		.cells (cells.sink),
		.rd_idx (rd_idx),
		.rom_addr (rom_addr),
		.glyph (glyph.source)
	);

	pixel_shade pixel_shade_inst (
		.clk (clk),
		.rst_n (rst_n),
		.rom_q (rom_q),
		.glyph (glyph.sink),
		.rgb (rgb),
		.hsync (hsync),
		.vsync (vsync),
		.de (de)
	);

endmodule

`default_nettype wire

/* verif/textvga_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "textvga_settings.svh"

module textvga_checker (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic wr_req,
	input wire textvga_pkg::cell_idx_t wr_idx,
	input wire textvga_pkg::char_code_t wr_char,
	input wire logic wr_ack,
	input wire textvga_pkg::row_t sel_row,
	input wire textvga_pkg::rom_addr_t rom_addr,
	input wire textvga_pkg::rgb_t rgb,
	input wire logic hsync,
	input wire logic vsync,
	input wire logic de,
	input wire logic check_en,
	output int errors,
	output int pixels
);
	import textvga_pkg::*;

	char_code_t shadow [`CELL_COUNT]; // What the screen should show
	logic req_d, ack_d, hs_d, vs_d, de_d;
	logic hs_seen, vs_seen;
	int hs_period, hs_width, vs_period, vs_width;
	int x, y; // Pixel position rebuilt from de and vsync
	int cycle_err;
	int shown;
	rgb_t expected;
	rom_addr_t expected_addr;
	rom_addr_t addr_d1; // rom_addr runs two cycles ahead of rgb
	rom_addr_t addr_d2;

	function automatic glyph_row_t font_row(input char_code_t code, input int line);
		if (code == '0) begin
			return '0;
		end
		return glyph_row_t'(int'(code) * 3 + line);
	endfunction

	function automatic rgb_t ref_color(input int px, input int py);
		int fc;
		int fl;
		int idx;
		glyph_row_t bits;
		logic fg;
		fc = px % `CELL_W;
		fl = py % `CELL_H;
		idx = (py / `CELL_H) * `GRID_COLS + px / `CELL_W;
		bits = font_row(shadow[cell_idx_t'(idx)], fl);
		fg = 1'b0;
		if (fc < `FONT_W && fl < `FONT_H) begin
			fg = bits[fontcol_t'(`FONT_W - 1 - fc)]; // MSB is leftmost
		end
		if (row_t'(py / `CELL_H) == sel_row) begin
			return fg ? `COLOR_SEL_TEXT : `COLOR_SEL_BG;
		end
		return fg ? `COLOR_TEXT : `COLOR_BG;
	endfunction

	// Spacing row still addresses the last glyph line
	function automatic rom_addr_t ref_addr(input int px, input int py);
		int fl;
		int idx;
		fl = py % `CELL_H;
		idx = (py / `CELL_H) * `GRID_COLS + px / `CELL_W;
		if (fl >= `FONT_H) begin
			fl = `FONT_H - 1;
		end
		return {fontline_t'(fl), shadow[cell_idx_t'(idx)]};
	endfunction

	task automatic show_mismatch(input string name, input int got, input int exp);
		cycle_err++;
		if (shown < 20) begin
			$display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
		shown++;
	endtask

	always @(posedge clk) begin
		cycle_err = 0;
		if (!rst_n) begin
			for (int i = 0; i < `CELL_COUNT; i++) begin
				shadow[cell_idx_t'(i)] <= '0;
			end
			{req_d, ack_d, hs_d, vs_d, de_d} <= '0;
			{hs_seen, vs_seen} <= '0;
			y <= 0;
			errors <= 0;
			pixels <= 0;
		end else begin
			{req_d, ack_d, hs_d, vs_d, de_d} <= {wr_req, wr_ack, hsync, vsync, de};
			addr_d1 <= rom_addr;
			addr_d2 <= addr_d1;

			// Write accepted on this edge
			if (wr_req && !wr_ack && int'(wr_idx) < `CELL_COUNT) begin
				shadow[wr_idx] <= wr_char;
			end
			if (wr_ack && !ack_d && !req_d) show_mismatch("wr_ack without wr_req", 1, 0);
			if (!wr_ack && ack_d && req_d) show_mismatch("wr_ack during wr_req", 0, 1);
			if (wr_ack && ack_d && !req_d) show_mismatch("wr_ack after release", 1, 0);

			if (hsync && !hs_d) begin
				if (hs_seen && hs_period != `H_TOTAL) begin
					show_mismatch("hsync period", hs_period, `H_TOTAL);
				end
				hs_seen <= 1'b1;
				hs_period <= 1;
			end else begin
				hs_period <= hs_period + 1;
			end
			if (hsync) hs_width <= hs_d ? hs_width + 1 : 1;
			if (!hsync && hs_d && hs_width != `H_SYNC) begin
				show_mismatch("hsync width", hs_width, `H_SYNC);
			end

			// Vertical timing counted in clock cycles
			if (vsync && !vs_d) begin
				if (vs_seen && vs_period != `V_TOTAL * `H_TOTAL) begin
					show_mismatch("vsync period", vs_period, `V_TOTAL * `H_TOTAL);
				end
				if (y != `RES_V) show_mismatch("lines with de", y, `RES_V);
				vs_seen <= 1'b1;
				vs_period <= 1;
			end else begin
				vs_period <= vs_period + 1;
			end
			if (vsync) vs_width <= vs_d ? vs_width + 1 : 1;
			if (!vsync && vs_d && vs_width != `V_SYNC * `H_TOTAL) begin
				show_mismatch("vsync width", vs_width, `V_SYNC * `H_TOTAL);
			end

			if (de) begin
				expected = ref_color(x, y);
				expected_addr = ref_addr(x, y);
				if (check_en) begin
					pixels <= pixels + 1;
					if (rgb !== expected) begin
						show_mismatch($sformatf("rgb at x=%0d y=%0d", x, y), int'(rgb),
							int'(expected));
					end
					if (addr_d2 !== expected_addr) begin
						show_mismatch($sformatf("rom_addr at x=%0d y=%0d", x, y),
							int'(addr_d2), int'(expected_addr));
					end
				end
				x <= x + 1;
			end else begin
				x <= 0;
				if (rgb !== 3'b000) show_mismatch("rgb in blanking", int'(rgb), 0);
				if (de_d && x != `RES_H) show_mismatch("de cycles per line", x, `RES_H);
			end
			if (vsync) begin
				y <= 0;
			end else if (de_d && !de) begin
				y <= y + 1; // Line with de has ended
			end
			errors <= errors + cycle_err;
		end
	end

endmodule

`default_nettype wire

/* verif/textvga_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "textvga_settings.svh"

module textvga_tb;
	import textvga_pkg::*;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int FRAME_PIXELS = `RES_H * `RES_V;
	localparam int TIMEOUT = 8 * FRAME_CYCLES + 1600; // Eight frames plus write traffic
	localparam int ACK_LIMIT = 16;

	logic clk;
	logic rst_n;
	logic wr_req;
	cell_idx_t wr_idx;
	char_code_t wr_char;
	row_t sel_row;
	glyph_row_t rom_q;
	logic wr_ack;
	rom_addr_t rom_addr;
	rgb_t rgb;
	logic hsync, vsync, de;
	logic check_en;
	int errors, pixels;
	int tb_errors, tests_run, tests_failed;
	int cycles;
	int seed;

	textvga_top textvga_top_inst (
		.clk (clk),
		.rst_n (rst_n),
		.wr_req (wr_req),
		.wr_idx (wr_idx),
		.wr_char (wr_char),
		.sel_row (sel_row),
		.rom_q (rom_q),
		.wr_ack (wr_ack),
		.rom_addr (rom_addr),
		.rgb (rgb),
		.hsync (hsync),
		.vsync (vsync),
		.de (de)
	);

	textvga_checker textvga_checker_inst (
		.clk (clk),
		.rst_n (rst_n),
		.wr_req (wr_req),
		.wr_idx (wr_idx),
		.wr_char (wr_char),
		.wr_ack (wr_ack),
		.sel_row (sel_row),
		.rom_addr (rom_addr),
		.rgb (rgb),
		.hsync (hsync),
		.vsync (vsync),
		.de (de),
		.check_en (check_en),
		.errors (errors),
		.pixels (pixels)
	);

	function automatic glyph_row_t font_row(input char_code_t code, input int line);
		if (code == '0) begin
			return '0;
		end
		return glyph_row_t'(int'(code) * 3 + line);
	endfunction

	// Font ROM model with one cycle read
	always @(posedge clk) begin
		rom_q <= font_row(rom_addr[6:0], int'(rom_addr[9:7]));
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Run stopped at the cycle limit of %0d", TIMEOUT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic wait_vsync(input logic level);
		while (vsync !== level) begin
			@(posedge clk);
		end
	endtask

	// Compare one whole frame that starts after all writes
	task automatic check_frame();
		int pix_before;
		wait_vsync(1'b1);
		wait_vsync(1'b0);
		pix_before = pixels;
		check_en <= 1'b1;
		wait_vsync(1'b1);
		check_en <= 1'b0;
		if (pixels - pix_before != FRAME_PIXELS) begin
			$display("Frame check saw %0d pixels instead of %0d", pixels - pix_before, FRAME_PIXELS);
			tb_errors++;
		end
	endtask

	task automatic write_cell(input cell_idx_t idx, input char_code_t code, input int hold);
		int waited;
		wr_idx <= idx;
		wr_char <= code;
		wr_req <= 1'b1;
		waited = 0;
		@(posedge clk);
		while (!wr_ack && waited < ACK_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (!wr_ack) begin
			$display("Write to cell %0d was never acknowledged", idx);
			tb_errors++;
		end
		repeat (hold) @(posedge clk); // Host stretches the request
		wr_req <= 1'b0;
		waited = 0;
		@(posedge clk);
		while (wr_ack && waited < ACK_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (wr_ack) begin
			$display("wr_ack stayed high after the request for cell %0d ended", idx);
			tb_errors++;
		end
	endtask

	task automatic finish_test(input string name, input int mark);
		int found;
		@(posedge clk); // Checker counts from the closing edge land here
		found = errors + tb_errors - mark;
		tests_run++;
		if (found == 0) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, name, found);
		end
	endtask

	initial begin
		int mark;
		seed = 40;
		rst_n = 1'b0;
		wr_req = 1'b0;
		wr_idx = '0;
		wr_char = '0;
		sel_row = 3'd7; // Points at no row
		rom_q = '0;
		check_en = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Two vsync pulses so a whole frame period is measured
		mark = errors + tb_errors;
		wait_vsync(1'b1);
		wait_vsync(1'b0);
		wait_vsync(1'b1);
		finish_test("raster timing", mark);

		mark = errors + tb_errors;
		check_frame();
		finish_test("blank frame after reset", mark);

		mark = errors + tb_errors;
		write_cell(7'd65, 7'h2a, 0);
		write_cell(7'd127, 7'h11, 3);
		write_cell(7'd100, 7'h7f, 1);
		check_frame();
		finish_test("handshake and out of range writes", mark);

		mark = errors + tb_errors;
		repeat (`CELL_COUNT) begin
			write_cell(cell_idx_t'({$random(seed)} % `CELL_COUNT), char_code_t'($random(seed)),
				{$random(seed)} % 3);
		end
		check_frame();
		finish_test("random text", mark);

		mark = errors + tb_errors;
		sel_row <= 3'd2;
		check_frame();
		finish_test("selected row", mark);

		@(negedge clk); // Counts from the last edge have settled
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			errors + tb_errors);
		if (tests_failed == 0 && errors + tb_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* textvga.f */
+incdir+hw
hw/textvga_pkg.sv
hw/cell_if.sv
hw/raster_timing.sv
hw/text_buffer.sv
hw/glyph_fetch.sv
hw/pixel_shade.sv
hw/textvga_top.sv
verif/textvga_checker.sv
verif/textvga_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the textvga testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module textvga_tb -f textvga.f -o textvga_sim

./obj_dir/textvga_sim > sim.log 2>&1
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
